// ==== design/dcache_pkg.sv ====
package dcache_pkg;

    // byte address and data word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // four words, word 0 in the low bits
    typedef logic [127:0] line_t;

    // byte enables of one word
    typedef logic [3:0] mask_t;

    // tag for the default 16 sets, address bits 31 down to 8
    typedef logic [23:0] tag_t;

    // word offset is address bits 3 down to 2
    localparam int BANK_WIDTH = 2;
    localparam int NUM_BANKS = 1 << BANK_WIDTH;

    // byte-in-line bits
    localparam int OFFSET_WIDTH = 4;

    // fixed by the single lru bit per set
    localparam int NUM_WAYS = 2;

    typedef enum logic [1:0] {
        idle,
        wait_mem,
        install
    } refill_state_t;

endpackage

// ==== design/dcache_arrays.sv ====
`timescale 1ns/1ps

module dcache_arrays #(
    parameter int SET_WIDTH = 4,
    localparam int TAG_WIDTH = 32 - SET_WIDTH - dcache_pkg::OFFSET_WIDTH
) (
    input  logic clk,
    input  logic rst,
    input  logic rd_en,
    input  logic [SET_WIDTH-1:0] rd_index,
    output logic [dcache_pkg::NUM_WAYS-1:0][TAG_WIDTH-1:0] rd_tags,
    output logic [dcache_pkg::NUM_WAYS-1:0] rd_valid,
    output logic [dcache_pkg::NUM_WAYS-1:0] rd_dirty,
    output logic rd_lru,
    output dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0] rd_data,
    input  logic wr_en,
    input  logic wr_way,
    input  logic [SET_WIDTH-1:0] wr_index,
    input  logic [TAG_WIDTH-1:0] wr_tag,
    input  logic wr_valid_set,
    input  logic wr_dirty_value,
    input  dcache_pkg::line_t wr_data,
    input  dcache_pkg::mask_t [dcache_pkg::NUM_BANKS-1:0] wr_word_mask,
    input  logic lru_en,
    input  logic [SET_WIDTH-1:0] lru_index,
    input  logic lru_way
);
    import dcache_pkg::*;

    localparam int NUM_SETS = 1 << SET_WIDTH;
    localparam int WORD_BITS = $bits(word_t);
    localparam int BYTES_PER_WORD = $bits(mask_t);

    logic [TAG_WIDTH-1:0] tag_mem [NUM_WAYS][NUM_SETS];
    line_t data_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty_q;
    logic [NUM_SETS-1:0] lru_q;

    // tag only changes on a line install
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (wr_valid_set) begin
                tag_mem[wr_way][wr_index] <= wr_tag;
            end
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int k = 0; k < BYTES_PER_WORD; k++) begin
                    if (wr_word_mask[b][k]) begin
                        data_mem[wr_way][wr_index][b*WORD_BITS + k*8 +: 8] <=
                            wr_data[b*WORD_BITS + k*8 +: 8];
                    end
                end
            end
        end
    end

    // both ways of the set, read together
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                rd_tags[w] <= tag_mem[w][rd_index];
                rd_data[w] <= data_mem[w][rd_index];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q <= '0;
            rd_valid <= '0;
            rd_dirty <= '0;
            rd_lru <= 1'b0;
        end else begin
            if (wr_en) begin
                if (wr_valid_set) begin
                    valid_q[wr_index][wr_way] <= 1'b1;
                end
                dirty_q[wr_index][wr_way] <= wr_dirty_value;
            end
            if (lru_en) begin
                lru_q[lru_index] <= lru_way;
            end
            if (rd_en) begin
                rd_valid <= valid_q[rd_index];
                rd_dirty <= dirty_q[rd_index];
                // hit on the same set in this cycle is the newer value
                rd_lru <= (lru_en && lru_index == rd_index) ? lru_way : lru_q[rd_index];
            end
        end
    end

endmodule

// ==== design/dcache_load_pipe.sv ====
`timescale 1ns/1ps

module dcache_load_pipe #(
    parameter int SET_WIDTH = 4,
    localparam int TAG_WIDTH = 32 - SET_WIDTH - dcache_pkg::OFFSET_WIDTH
) (
    input  logic clk,
    input  logic rst,
    input  logic accept,
    input  dcache_pkg::addr_t addr,
    input  logic [dcache_pkg::NUM_WAYS-1:0][TAG_WIDTH-1:0] rd_tags,
    input  logic [dcache_pkg::NUM_WAYS-1:0] rd_valid,
    input  dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0] rd_data,
    output logic resp_valid,
    output logic hit,
    output dcache_pkg::word_t data,
    output logic miss_valid,
    output dcache_pkg::addr_t miss_addr,
    output logic lru_en,
    output logic lru_way
);
    import dcache_pkg::*;

    logic s1_valid;
    addr_t s1_addr;
    logic [NUM_WAYS-1:0] way_hit;
    logic s1_hit;
    logic hit_way;
    logic [BANK_WIDTH-1:0] bank;
    word_t hit_word;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_addr <= addr;
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = rd_valid[w] && rd_tags[w] == s1_addr[31 -: TAG_WIDTH];
        end
    end

    assign s1_hit = |way_hit;
    // two ways, so the upper hit bit is the way number
    assign hit_way = way_hit[1];
    assign bank = s1_addr[OFFSET_WIDTH-1 -: BANK_WIDTH];
    assign hit_word = rd_data[hit_way][bank*$bits(word_t) +: $bits(word_t)];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_valid <= 1'b0;
            hit <= 1'b0;
        end else begin
            resp_valid <= s1_valid;
            hit <= s1_valid & s1_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            data <= hit_word;
        end
    end

    assign miss_valid = s1_valid & ~s1_hit;
    assign miss_addr = s1_addr;
    assign lru_en = s1_valid & s1_hit;
    assign lru_way = hit_way;

endmodule

// ==== design/dcache_store_pipe.sv ====
`timescale 1ns/1ps

module dcache_store_pipe #(
    parameter int SET_WIDTH = 4,
    localparam int TAG_WIDTH = 32 - SET_WIDTH - dcache_pkg::OFFSET_WIDTH
) (
    input  logic clk,
    input  logic rst,
    input  logic accept,
    input  dcache_pkg::addr_t addr,
    input  dcache_pkg::word_t data,
    input  dcache_pkg::mask_t mask,
    input  logic [dcache_pkg::NUM_WAYS-1:0][TAG_WIDTH-1:0] rd_tags,
    input  logic [dcache_pkg::NUM_WAYS-1:0] rd_valid,
    output logic busy,
    output logic done,
    output logic hit,
    output logic wr_en,
    output logic wr_way,
    output logic [SET_WIDTH-1:0] wr_index,
    output dcache_pkg::line_t wr_data,
    output dcache_pkg::mask_t [dcache_pkg::NUM_BANKS-1:0] wr_word_mask,
    output logic miss_valid,
    output dcache_pkg::addr_t miss_addr,
    output logic lru_en,
    output logic lru_way
);
    import dcache_pkg::*;

    logic s1_valid;
    addr_t s1_addr;
    word_t s1_data;
    mask_t s1_mask;
    logic [NUM_WAYS-1:0] way_hit;
    logic s1_hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
            done <= 1'b0;
            hit <= 1'b0;
        end else begin
            s1_valid <= accept;
            done <= s1_valid;
            hit <= s1_valid & s1_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_addr <= addr;
            s1_data <= data;
            s1_mask <= mask;
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = rd_valid[w] && rd_tags[w] == s1_addr[31 -: TAG_WIDTH];
        end
    end

    assign s1_hit = |way_hit;
    assign busy = s1_valid | done;

    // masked write into the hit way, sets dirty
    assign wr_en = s1_valid & s1_hit;
    assign wr_way = way_hit[1];
    assign wr_index = s1_addr[OFFSET_WIDTH +: SET_WIDTH];
    assign wr_data = {NUM_BANKS{s1_data}};

    always_comb begin
        wr_word_mask = '0;
        wr_word_mask[s1_addr[OFFSET_WIDTH-1 -: BANK_WIDTH]] = s1_mask;
    end

    assign miss_valid = s1_valid & ~s1_hit;
    assign miss_addr = s1_addr;
    assign lru_en = wr_en;
    assign lru_way = way_hit[1];

endmodule

// ==== design/dcache_refill.sv ====
`timescale 1ns/1ps

module dcache_refill #(
    parameter int SET_WIDTH = 4,
    localparam int TAG_WIDTH = 32 - SET_WIDTH - dcache_pkg::OFFSET_WIDTH
) (
    input  logic clk,
    input  logic rst,
    input  logic miss_valid,
    input  dcache_pkg::addr_t miss_addr,
    input  logic [dcache_pkg::NUM_WAYS-1:0][TAG_WIDTH-1:0] set_tags,
    input  logic [dcache_pkg::NUM_WAYS-1:0] set_valid,
    input  logic [dcache_pkg::NUM_WAYS-1:0] set_dirty,
    input  logic set_lru,
    input  dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0] set_data,
    output logic mem_req,
    output dcache_pkg::addr_t mem_addr,
    input  logic mem_resp_valid,
    input  dcache_pkg::line_t mem_resp_data,
    output logic wb_valid,
    output dcache_pkg::addr_t wb_addr,
    output dcache_pkg::line_t wb_data,
    output logic busy,
    output logic wr_en,
    output logic wr_way,
    output logic [SET_WIDTH-1:0] wr_index,
    output logic [TAG_WIDTH-1:0] wr_tag,
    output dcache_pkg::line_t wr_data,
    output logic lru_en,
    output logic lru_way
);
    import dcache_pkg::*;

    refill_state_t state;
    logic start;
    logic victim;
    logic way_q;
    logic [TAG_WIDTH-1:0] tag_q;
    logic [SET_WIDTH-1:0] index_q;
    line_t line_q;

    // invalid way first, else the one lru does not mark
    always_comb begin
        if (!set_valid[0]) begin
            victim = 1'b0;
        end else if (!set_valid[1]) begin
            victim = 1'b1;
        end else begin
            victim = ~set_lru;
        end
    end

    // misses seen while busy are dropped, requester retries
    assign start = miss_valid && state == idle;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= start & set_valid[victim] & set_dirty[victim];
            case (state)
                idle: begin
                    if (start) begin
                        state <= wait_mem;
                    end
                end
                wait_mem: begin
                    if (mem_resp_valid) begin
                        state <= install;
                    end
                end
                install: state <= idle;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            tag_q <= miss_addr[31 -: TAG_WIDTH];
            index_q <= miss_addr[OFFSET_WIDTH +: SET_WIDTH];
            way_q <= victim;
            wb_addr <= {set_tags[victim], miss_addr[OFFSET_WIDTH +: SET_WIDTH],
                        {OFFSET_WIDTH{1'b0}}};
            wb_data <= set_data[victim];
        end
        if (state == wait_mem && mem_resp_valid) begin
            line_q <= mem_resp_data;
        end
    end

    assign busy = state != idle;
    assign mem_req = state == wait_mem;
    assign mem_addr = {tag_q, index_q, {OFFSET_WIDTH{1'b0}}};

    // install writes the whole line, clean
    assign wr_en = state == install;
    assign wr_way = way_q;
    assign wr_index = index_q;
    assign wr_tag = tag_q;
    assign wr_data = line_q;
    assign lru_en = wr_en;
    assign lru_way = way_q;

endmodule

// ==== design/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top #(
    parameter int SET_WIDTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic load_req,
    input  dcache_pkg::addr_t load_addr,
    output logic load_ready,
    output logic load_resp_valid,
    output logic load_hit,
    output dcache_pkg::word_t load_data,
    input  logic store_req,
    input  dcache_pkg::addr_t store_addr,
    input  dcache_pkg::word_t store_data,
    input  dcache_pkg::mask_t store_mask,
    output logic store_ready,
    output logic store_done,
    output logic store_hit,
    output logic mem_req,
    output dcache_pkg::addr_t mem_addr,
    input  logic mem_resp_valid,
    input  dcache_pkg::line_t mem_resp_data,
    output logic wb_valid,
    output dcache_pkg::addr_t wb_addr,
    output dcache_pkg::line_t wb_data
);
    import dcache_pkg::*;

    localparam int TAG_WIDTH = 32 - SET_WIDTH - OFFSET_WIDTH;

    logic load_accept, store_accept, load_inflight, store_busy, refill_busy;

    logic rd_en, rd_lru;
    logic [SET_WIDTH-1:0] rd_index;
    logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] rd_tags;
    logic [NUM_WAYS-1:0] rd_valid, rd_dirty;
    line_t [NUM_WAYS-1:0] rd_data;
    logic wr_en, wr_way, lru_en, lru_way;
    logic [SET_WIDTH-1:0] wr_index, lru_index;
    line_t wr_data;
    mask_t [NUM_BANKS-1:0] wr_word_mask;

    logic ld_miss_valid, ld_lru_en, ld_lru_way;
    addr_t ld_miss_addr;
    logic st_wr_en, st_wr_way, st_miss_valid, st_lru_en, st_lru_way;
    logic [SET_WIDTH-1:0] st_wr_index;
    line_t st_wr_data;
    mask_t [NUM_BANKS-1:0] st_wr_word_mask;
    addr_t st_miss_addr;
    logic rf_wr_en, rf_wr_way, rf_lru_en, rf_lru_way;
    logic [SET_WIDTH-1:0] rf_wr_index;
    logic [TAG_WIDTH-1:0] rf_wr_tag;
    line_t rf_wr_data;
    logic miss_valid;
    addr_t miss_addr;

    // stores win over loads
    assign load_ready = ~refill_busy & ~store_busy & ~store_req;
    assign store_ready = ~refill_busy & ~load_inflight & ~store_busy;
    assign load_accept = load_req & load_ready;
    assign store_accept = store_req & store_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_inflight <= 1'b0;
        end else begin
            load_inflight <= load_accept;
        end
    end

    assign rd_en = load_accept | store_accept;
    assign rd_index = store_accept ? store_addr[OFFSET_WIDTH +: SET_WIDTH]
                                   : load_addr[OFFSET_WIDTH +: SET_WIDTH];

    // install and store hit write are never active together
    assign wr_en = rf_wr_en | st_wr_en;
    assign wr_way = rf_wr_en ? rf_wr_way : st_wr_way;
    assign wr_index = rf_wr_en ? rf_wr_index : st_wr_index;
    assign wr_data = rf_wr_en ? rf_wr_data : st_wr_data;
    assign wr_word_mask = rf_wr_en ? '1 : st_wr_word_mask;

    assign lru_en = rf_lru_en | st_lru_en | ld_lru_en;
    assign lru_way = rf_lru_en ? rf_lru_way : (st_lru_en ? st_lru_way : ld_lru_way);
    assign lru_index = rf_lru_en ? rf_wr_index
                     : (st_lru_en ? st_wr_index : ld_miss_addr[OFFSET_WIDTH +: SET_WIDTH]);

    assign miss_valid = ld_miss_valid | st_miss_valid;
    assign miss_addr = st_miss_valid ? st_miss_addr : ld_miss_addr;

    dcache_arrays #(.SET_WIDTH(SET_WIDTH)) u_arrays (
        .clk, .rst, .rd_en, .rd_index, .rd_tags, .rd_valid, .rd_dirty, .rd_lru, .rd_data,
        .wr_en, .wr_way, .wr_index, .wr_tag(rf_wr_tag), .wr_valid_set(rf_wr_en),
        .wr_dirty_value(~rf_wr_en), .wr_data, .wr_word_mask,
        .lru_en, .lru_index, .lru_way
    );

    dcache_load_pipe #(.SET_WIDTH(SET_WIDTH)) u_load_pipe (
        .clk, .rst, .accept(load_accept), .addr(load_addr),
        .rd_tags, .rd_valid, .rd_data,
        .resp_valid(load_resp_valid), .hit(load_hit), .data(load_data),
        .miss_valid(ld_miss_valid), .miss_addr(ld_miss_addr),
        .lru_en(ld_lru_en), .lru_way(ld_lru_way)
    );

    dcache_store_pipe #(.SET_WIDTH(SET_WIDTH)) u_store_pipe (
        .clk, .rst, .accept(store_accept), .addr(store_addr),
        .data(store_data), .mask(store_mask), .rd_tags, .rd_valid,
        .busy(store_busy), .done(store_done), .hit(store_hit),
        .wr_en(st_wr_en), .wr_way(st_wr_way), .wr_index(st_wr_index),
        .wr_data(st_wr_data), .wr_word_mask(st_wr_word_mask),
        .miss_valid(st_miss_valid), .miss_addr(st_miss_addr),
        .lru_en(st_lru_en), .lru_way(st_lru_way)
    );

    dcache_refill #(.SET_WIDTH(SET_WIDTH)) u_refill (
        .clk, .rst, .miss_valid, .miss_addr,
        .set_tags(rd_tags), .set_valid(rd_valid), .set_dirty(rd_dirty),
        .set_lru(rd_lru), .set_data(rd_data),
        .mem_req, .mem_addr, .mem_resp_valid, .mem_resp_data,
        .wb_valid, .wb_addr, .wb_data, .busy(refill_busy),
        .wr_en(rf_wr_en), .wr_way(rf_wr_way), .wr_index(rf_wr_index),
        .wr_tag(rf_wr_tag), .wr_data(rf_wr_data),
        .lru_en(rf_lru_en), .lru_way(rf_lru_way)
    );

endmodule

// ==== bench/tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int SET_WIDTH = 4;
    localparam int NUM_SETS = 1 << SET_WIDTH;
    localparam int NUM_OPS = 400;
    localparam int CYCLE_LIMIT = NUM_OPS * 12;

    logic clk;
    logic rst;
    logic load_req;
    addr_t load_addr;
    logic load_ready;
    logic load_resp_valid;
    logic load_hit;
    word_t load_data;
    logic store_req;
    addr_t store_addr;
    word_t store_data;
    mask_t store_mask;
    logic store_ready;
    logic store_done;
    logic store_hit;
    logic mem_req;
    addr_t mem_addr;
    logic mem_resp_valid;
    line_t mem_resp_data;
    logic wb_valid;
    addr_t wb_addr;
    line_t wb_data;

    // backing memory, holds every written-back line
    line_t mem_lines [addr_t];

    // cache model
    tag_t m_tag [NUM_SETS][NUM_WAYS];
    logic m_valid [NUM_SETS][NUM_WAYS];
    logic m_dirty [NUM_SETS][NUM_WAYS];
    logic m_lru [NUM_SETS];
    line_t m_data [NUM_SETS][NUM_WAYS];

    addr_t pool [6];
    int cycles = 0;
    int wb_seen = 0;
    int wb_expected = 0;

    dcache_top #(.SET_WIDTH(SET_WIDTH)) u_dcache_top (
        .clk, .rst, .load_req, .load_addr, .load_ready, .load_resp_valid, .load_hit,
        .load_data, .store_req, .store_addr, .store_data, .store_mask, .store_ready,
        .store_done, .store_hit, .mem_req, .mem_addr, .mem_resp_valid, .mem_resp_data,
        .wb_valid, .wb_addr, .wb_data
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("cycle limit of %0d reached before all operations finished", CYCLE_LIMIT);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string name, input logic [127:0] actual,
                         input logic [127:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic word_t fill_word(addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic line_t line_read(addr_t line_addr);
        line_t l;
        if (mem_lines.exists(line_addr)) begin
            return mem_lines[line_addr];
        end
        for (int i = 0; i < 4; i++) begin
            l[i*32 +: 32] = fill_word(line_addr + addr_t'(4 * i));
        end
        return l;
    endfunction

    // memory answers after 1 to 6 cycles
    initial begin
        int delay;
        mem_resp_valid = 1'b0;
        mem_resp_data = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_req === 1'b1) begin
                delay = $urandom_range(1, 6);
                repeat (delay - 1) begin
                    @(posedge clk);
                    #1;
                end
                mem_resp_data = line_read(mem_addr);
                mem_resp_valid = 1'b1;
                @(posedge clk);
                #1;
                mem_resp_valid = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (wb_valid === 1'b1) begin
            mem_lines[wb_addr] = wb_data;
            wb_seen = wb_seen + 1;
        end
    end

    // -1 when the model does not hold the line
    function automatic int find_way(addr_t a);
        logic [SET_WIDTH-1:0] s;
        s = a[OFFSET_WIDTH +: SET_WIDTH];
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == a[31:8]) begin
                return w;
            end
        end
        return -1;
    endfunction

    task automatic start_refill(input addr_t a, output int victim);
        logic [SET_WIDTH-1:0] s;
        s = a[OFFSET_WIDTH +: SET_WIDTH];
        if (!m_valid[s][0]) begin
            victim = 0;
        end else if (!m_valid[s][1]) begin
            victim = 1;
        end else begin
            victim = m_lru[s] ? 0 : 1;
        end
        check("mem_req", 128'(mem_req), 128'(1));
        check("mem_addr", 128'(mem_addr), 128'({a[31:4], 4'h0}));
        if (m_valid[s][victim] && m_dirty[s][victim]) begin
            check("wb_valid", 128'(wb_valid), 128'(1));
            check("wb_addr", 128'(wb_addr), 128'({m_tag[s][victim], s, 4'h0}));
            check("wb_data", wb_data, m_data[s][victim]);
            wb_expected = wb_expected + 1;
        end else begin
            check("wb_valid", 128'(wb_valid), 128'(0));
        end
    endtask

    task automatic finish_refill(input addr_t a, input int victim);
        logic [SET_WIDTH-1:0] s;
        s = a[OFFSET_WIDTH +: SET_WIDTH];
        @(negedge clk);
        while (mem_resp_valid !== 1'b1) begin
            check("load_ready", 128'(load_ready), 128'(0));
            check("store_ready", 128'(store_ready), 128'(0));
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        // install cycle
        check("load_ready", 128'(load_ready), 128'(0));
        check("store_ready", 128'(store_ready), 128'(0));
        @(posedge clk);
        #1;
        check("load_ready", 128'(load_ready), 128'(1));
        check("store_ready", 128'(store_ready), 128'(1));
        m_tag[s][victim] = a[31:8];
        m_valid[s][victim] = 1'b1;
        m_dirty[s][victim] = 1'b0;
        m_lru[s] = victim[0];
        m_data[s][victim] = line_read({a[31:4], 4'h0});
    endtask

    // compare one response against the model and update it
    task automatic load_response(input addr_t a, output int way);
        logic [SET_WIDTH-1:0] s;
        s = a[OFFSET_WIDTH +: SET_WIDTH];
        way = find_way(a);
        check("load_resp_valid", 128'(load_resp_valid), 128'(1));
        check("load_hit", 128'(load_hit), 128'(way >= 0));
        if (way >= 0) begin
            check("load_data", 128'(load_data), 128'(m_data[s][way][32*int'(a[3:2]) +: 32]));
            m_lru[s] = way[0];
        end
    endtask

    task automatic issue(input logic is_store, input addr_t a, input word_t d,
                         input mask_t m, output logic hit);
        logic [SET_WIDTH-1:0] s;
        int way;
        s = a[OFFSET_WIDTH +: SET_WIDTH];
        if (is_store) begin
            store_req = 1'b1;
            store_addr = a;
            store_data = d;
            store_mask = m;
        end else begin
            load_req = 1'b1;
            load_addr = a;
        end
        @(negedge clk);
        while (!(is_store ? store_ready : load_ready)) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        store_req = 1'b0;
        load_req = 1'b0;
        check("load_resp_valid", 128'(load_resp_valid), 128'(0));
        check("store_done", 128'(store_done), 128'(0));
        check("mem_req", 128'(mem_req), 128'(0));
        @(posedge clk);
        #1;
        if (is_store) begin
            way = find_way(a);
            check("store_done", 128'(store_done), 128'(1));
            check("store_hit", 128'(store_hit), 128'(way >= 0));
            if (way >= 0) begin
                for (int k = 0; k < 4; k++) begin
                    if (m[k]) begin
                        m_data[s][way][32*int'(a[3:2]) + 8*k +: 8] = d[8*k +: 8];
                    end
                end
                m_dirty[s][way] = 1'b1;
                m_lru[s] = way[0];
            end
        end else begin
            load_response(a, way);
        end
        hit = way >= 0;
        if (hit) begin
            check("wb_valid", 128'(wb_valid), 128'(0));
        end
    endtask

    // a miss is refilled and then retried
    task automatic do_op(input logic is_store, input addr_t a, input word_t d,
                         input mask_t m);
        logic hit;
        int victim;
        issue(is_store, a, d, m, hit);
        if (!hit) begin
            start_refill(a, victim);
            finish_refill(a, victim);
            issue(is_store, a, d, m, hit);
        end
    endtask

    task automatic load_pair(input addr_t a0, input addr_t a1);
        int w0;
        int w1;
        int v0;
        int v1;
        load_req = 1'b1;
        load_addr = a0;
        @(negedge clk);
        while (!load_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        load_addr = a1;
        @(negedge clk);
        check("load_ready", 128'(load_ready), 128'(1));
        @(posedge clk);
        #1;
        load_req = 1'b0;
        load_response(a0, w0);
        if (w0 < 0) begin
            start_refill(a0, v0);
            // memory may answer before the second response is out
            fork
                begin
                    @(posedge clk);
                    #1;
                    load_response(a1, w1);
                end
                finish_refill(a0, v0);
            join
            do_op(1'b0, a0, '0, '0);
        end else begin
            @(posedge clk);
            #1;
            load_response(a1, w1);
            if (w1 < 0) begin
                start_refill(a1, v1);
                finish_refill(a1, v1);
            end
        end
        // second miss is dropped while the first refill runs
        if (w1 < 0) begin
            do_op(1'b0, a1, '0, '0);
        end
    endtask

    initial begin
        int kind;
        int idx;
        word_t bits;
        addr_t a;
        addr_t a2;
        void'($urandom(34304));
        rst = 1'b1;
        load_req = 1'b0;
        load_addr = '0;
        store_req = 1'b0;
        store_addr = '0;
        store_data = '0;
        store_mask = '0;
        // three lines in set 3, three in set 9
        pool[0] = 32'h0000_1230;
        pool[1] = 32'h0000_a790;
        pool[2] = 32'h001c_0330;
        pool[3] = 32'h0042_5e90;
        pool[4] = 32'h7f00_0030;
        pool[5] = 32'h0000_0b90;
        for (int i = 0; i < NUM_SETS; i++) begin
            m_lru[i] = 1'b0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_valid[i][w] = 1'b0;
                m_dirty[i][w] = 1'b0;
            end
        end
        repeat (8) begin
            @(posedge clk);
        end
        #1;
        rst = 1'b0;
        repeat (4) begin
            @(posedge clk);
            #1;
            check("load_resp_valid", 128'(load_resp_valid), 128'(0));
            check("store_done", 128'(store_done), 128'(0));
            check("mem_req", 128'(mem_req), 128'(0));
            check("wb_valid", 128'(wb_valid), 128'(0));
            check("load_ready", 128'(load_ready), 128'(1));
            check("store_ready", 128'(store_ready), 128'(1));
        end
        for (int n = 0; n < NUM_OPS; n++) begin
            kind = $urandom_range(0, 99);
            idx = $urandom_range(0, 5);
            bits = $urandom;
            a = pool[idx] | {28'h0, bits[1:0], 2'b00};
            if (kind < 45) begin
                do_op(1'b0, a, '0, '0);
            end else if (kind < 85) begin
                do_op(1'b1, a, $urandom, bits[7:4]);
            end else begin
                idx = $urandom_range(0, 5);
                a2 = pool[idx] | {28'h0, bits[9:8], 2'b00};
                load_pair(a, a2);
            end
        end
        repeat (2) begin
            @(posedge clk);
        end
        check("wb pulse count", 128'(wb_seen), 128'(wb_expected));
        $display("Test passed");
        $finish;
    end

endmodule

// ==== build.f ====
design/dcache_pkg.sv
design/dcache_arrays.sv
design/dcache_load_pipe.sv
design/dcache_store_pipe.sv
design/dcache_refill.sv
design/dcache_top.sv
bench/tb_dcache.sv

// ==== Makefile ====
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP ?= tb_dcache
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary -j 0 --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
